/* decode_defs.svh */
// Decode stage widths

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Data path width
`define XLEN 32

// Architectural register index
`define REG_ADDR_W 5

// Completion buffer tag that wraps at 2**CB_TAG_W entries
`define CB_TAG_W 3

// Entries in the execute input buffer
// Decode starts out holding this many credits
`define EXEC_CREDITS 4

// Must hold the value EXEC_CREDITS
`define CREDIT_W 3

`endif

/* decode_pkg.sv */
// Decode stage types

`default_nettype none

`include "decode_defs.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0] word_t;

  // RV32I major opcodes handled by this stage
  typedef enum logic [6:0] {
    OP      = 7'b0110011,
    OP_IMM  = 7'b0010011,
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    MISCMEM = 7'b0001111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
  } alu_op_e;

  typedef enum logic {FU_ARITH, FU_LOADSTORE} fu_type_e;

  typedef enum logic [1:0] {SRC_A_RS1, SRC_A_IMM_S, SRC_A_PC, SRC_A_ZERO} src_a_e;

  typedef enum logic [1:0] {SRC_B_RS1, SRC_B_RS2, SRC_B_IMM_I, SRC_B_IMM_U} src_b_e;

  typedef enum logic [1:0] {WSRC_ALU, WSRC_PC4, WSRC_IMM_U} wsrc_e;

  // Instruction word formats listed MSB first
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm11_00;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm11_05;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm04_00;
    opcode_e               opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm31_12;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } u_fmt_t;

  // Scrambled J immediate
  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_01;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // Control fields held in the decode/execute latch
  typedef struct packed {
    fu_type_e              fu;
    alu_op_e               alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic                  wen;
    logic                  is_load;
    logic                  is_store;
    logic [2:0]            mem_width;
    logic                  is_jump;
    logic                  illegal;
  } ctrl_t;

endpackage

`default_nettype wire

/* decode_ctrl_if.sv */
// Decoded control bus

`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

interface decode_ctrl_if;
  import decode_pkg::*;

  logic [`REG_ADDR_W-1:0] rs1, rs2, rd;
  // Sign-extended immediates
  word_t    imm_i, imm_s, imm_u, imm_j;
  logic     shamt_sel;
  src_a_e   src_a_sel;
  src_b_e   src_b_sel;
  wsrc_e    wsrc;
  alu_op_e  alu_op;
  fu_type_e fu_type;
  logic     wen, is_jump, j_sel;
  logic     is_load, is_store;
  logic [2:0] mem_width;
  logic     is_fence, illegal;

  modport cu (
    output rs1, rs2, rd, imm_i, imm_s, imm_u, imm_j, shamt_sel,
           src_a_sel, src_b_sel, wsrc, alu_op, fu_type, wen, is_jump, j_sel,
           is_load, is_store, mem_width, is_fence, illegal
  );

  modport ops (
    input imm_i, imm_s, imm_u, imm_j, shamt_sel, src_a_sel, src_b_sel, wsrc, j_sel
  );

  modport issue (
    input rd, alu_op, fu_type, wen, is_jump, is_load, is_store, mem_width,
          is_fence, illegal
  );

endinterface

`default_nettype wire

/* control_unit.sv */
// Instruction decoder

`timescale 1ns/1ps
`default_nettype none

module control_unit (
  decode_ctrl_if.cu       ctrl,
  input decode_pkg::instr_u instr
);
  import decode_pkg::*;

  // Shared by OP and OP_IMM with funct7 bit 5 picking SUB and SRA
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign ctrl.rs1 = instr.r_fmt.rs1;
  assign ctrl.rs2 = instr.r_fmt.rs2;
  assign ctrl.rd  = instr.r_fmt.rd;

  assign ctrl.imm_i = {{20{instr.i_fmt.imm11_00[11]}}, instr.i_fmt.imm11_00};
  assign ctrl.imm_s = {{20{instr.s_fmt.imm11_05[6]}}, instr.s_fmt.imm11_05,
                       instr.s_fmt.imm04_00};
  assign ctrl.imm_u = {instr.u_fmt.imm31_12, 12'b0};
  assign ctrl.imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                       instr.j_fmt.imm11, instr.j_fmt.imm10_01, 1'b0};

  always_comb begin
    ctrl.shamt_sel = 1'b0;
    ctrl.src_a_sel = SRC_A_RS1;
    ctrl.src_b_sel = SRC_B_RS2;
    ctrl.wsrc      = WSRC_ALU;
    ctrl.alu_op    = ALU_ADD;
    ctrl.fu_type   = FU_ARITH;
    ctrl.wen       = 1'b0;
    ctrl.is_jump   = 1'b0;
    ctrl.j_sel     = 1'b0;
    ctrl.is_load   = 1'b0;
    ctrl.is_store  = 1'b0;
    ctrl.mem_width = 3'b000;
    ctrl.is_fence  = 1'b0;
    ctrl.illegal   = 1'b0;

    case (instr.r_fmt.opcode)
      OP: begin
        ctrl.wen    = 1'b1;
        ctrl.alu_op = alu_from_funct(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
      end
      OP_IMM: begin
        ctrl.wen       = 1'b1;
        ctrl.src_b_sel = SRC_B_IMM_I;
        // Shifts take only the low five immediate bits
        ctrl.shamt_sel = (instr.i_fmt.funct3 == 3'b001) || (instr.i_fmt.funct3 == 3'b101);
        ctrl.alu_op    = alu_from_funct(instr.i_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
      end
      LUI: begin
        ctrl.wen       = 1'b1;
        ctrl.src_b_sel = SRC_B_IMM_U;
        ctrl.wsrc      = WSRC_IMM_U;
        ctrl.alu_op    = ALU_COPY_B;
      end
      AUIPC: begin
        ctrl.wen       = 1'b1;
        ctrl.src_a_sel = SRC_A_PC;
        ctrl.src_b_sel = SRC_B_IMM_U;
      end
      JAL: begin
        ctrl.wen     = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.j_sel   = 1'b1;
        ctrl.wsrc    = WSRC_PC4;
      end
      JALR: begin
        ctrl.wen     = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.wsrc    = WSRC_PC4;
      end
      LOAD: begin
        ctrl.wen       = 1'b1;
        ctrl.fu_type   = FU_LOADSTORE;
        ctrl.is_load   = 1'b1;
        ctrl.src_b_sel = SRC_B_IMM_I;
        ctrl.mem_width = instr.i_fmt.funct3;
      end
      STORE: begin
        ctrl.fu_type   = FU_LOADSTORE;
        ctrl.is_store  = 1'b1;
        ctrl.src_a_sel = SRC_A_IMM_S;
        ctrl.src_b_sel = SRC_B_RS1;
        ctrl.mem_width = instr.s_fmt.funct3;
      end
      // Plain FENCE issues as a no-op
      MISCMEM: ctrl.is_fence = (instr.i_fmt.funct3 == 3'b001);
      default: ctrl.illegal  = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* operand_select.sv */
// Operand and jump target selection

`timescale 1ns/1ps
`default_nettype none

module operand_select (
  decode_ctrl_if.ops          ctrl,
  input  decode_pkg::word_t   pc,
  input  decode_pkg::word_t   rs1_data,
  input  decode_pkg::word_t   rs2_data,
  output decode_pkg::word_t   port_a,
  output decode_pkg::word_t   port_b,
  output decode_pkg::word_t   wdata,
  output decode_pkg::word_t   j_base,
  output decode_pkg::word_t   j_offset
);
  import decode_pkg::*;

  word_t imm_or_shamt;

  // Shift amount is zero-extended so the SRAI funct7 bit stays out
  assign imm_or_shamt = ctrl.shamt_sel ? {27'b0, ctrl.imm_i[4:0]} : ctrl.imm_i;

  always_comb begin
    case (ctrl.src_a_sel)
      SRC_A_RS1:   port_a = rs1_data;
      SRC_A_IMM_S: port_a = ctrl.imm_s;
      SRC_A_PC:    port_a = pc;
      default:     port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b_sel)
      SRC_B_RS1:   port_b = rs1_data;
      SRC_B_RS2:   port_b = rs2_data;
      SRC_B_IMM_I: port_b = imm_or_shamt;
      default:     port_b = ctrl.imm_u;
    endcase
  end

  // Link value for jumps and upper immediate for LUI
  always_comb begin
    case (ctrl.wsrc)
      WSRC_PC4:   wdata = pc + word_t'(4);
      WSRC_IMM_U: wdata = ctrl.imm_u;
      default:    wdata = '0;
    endcase
  end

  // JAL is PC relative while JALR uses rs1 through operand A
  assign j_base   = ctrl.j_sel ? pc : port_a;
  assign j_offset = ctrl.j_sel ? ctrl.imm_j : ctrl.imm_i;

endmodule

`default_nettype wire

/* fence_tracker.sv */
// FENCE.I cache flush tracker

`timescale 1ns/1ps
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic fence_accept,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic busy
);

  logic flush_q;
  logic iflushed, dflushed;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= fence_accept;
    end
  end

  assign icache_flush = flush_q;
  assign dcache_flush = flush_q;

  // Each cache's done pulse is kept until the other one arrives
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (fence_accept) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else begin
      if (iflush_done) iflushed <= 1'b1;
      if (dflush_done) dflushed <= 1'b1;
    end
  end

  assign busy = ~iflushed | ~dflushed;

endmodule

`default_nettype wire

/* issue_latch.sv */
// Credit-based issue and decode/execute latch

`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module issue_latch (
  input  logic                     CLK,
  input  logic                     nRST,
  decode_ctrl_if.issue             ctrl,
  input  logic                     fetch_valid,
  input  logic                     flush,
  input  logic                     fence_busy,
  input  logic                     ex_credit,
  output logic                     fetch_ready,
  output logic                     fence_accept,
  input  decode_pkg::word_t        pc,
  input  decode_pkg::word_t        port_a,
  input  decode_pkg::word_t        port_b,
  input  decode_pkg::word_t        wdata,
  input  decode_pkg::word_t        j_base,
  input  decode_pkg::word_t        j_offset,
  input  decode_pkg::word_t        store_data,
  output logic                     ex_valid,
  output decode_pkg::fu_type_e     ex_fu,
  output decode_pkg::alu_op_e      ex_alu_op,
  output logic [`REG_ADDR_W-1:0]   ex_rd,
  output logic                     ex_wen,
  output decode_pkg::word_t        ex_port_a,
  output decode_pkg::word_t        ex_port_b,
  output decode_pkg::word_t        ex_wdata,
  output decode_pkg::word_t        ex_store_data,
  output logic                     ex_is_load,
  output logic                     ex_is_store,
  output logic [2:0]               ex_mem_width,
  output logic                     ex_jump,
  output decode_pkg::word_t        ex_j_base,
  output decode_pkg::word_t        ex_j_offset,
  output decode_pkg::word_t        ex_pc,
  output logic [`CB_TAG_W-1:0]     ex_tag,
  output logic                     ex_illegal
);
  import decode_pkg::*;

  logic [`CREDIT_W-1:0] credits;
  logic [`CB_TAG_W-1:0] tag_q;
  logic                 accept, issue;
  ctrl_t                ctrl_d, ctrl_q;

  // Counter drops at the accepting edge, so the last credit closes ready next cycle
  assign fetch_ready  = ~flush & ~fence_busy & (credits != '0);
  assign accept       = fetch_valid & fetch_ready;
  assign fence_accept = accept & ctrl.is_fence;
  assign issue        = accept & ~ctrl.is_fence;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      credits <= `CREDIT_W'(`EXEC_CREDITS);
    end else if (issue && !ex_credit) begin
      credits <= credits - 1'b1;
    end else if (ex_credit && !issue) begin
      credits <= credits + 1'b1;
    end
  end

  // Completion buffer tail
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      tag_q <= '0;
    end else if (issue) begin
      tag_q <= tag_q + 1'b1;
    end
  end

  assign ctrl_d = '{fu: ctrl.fu_type, alu_op: ctrl.alu_op, rd: ctrl.rd, wen: ctrl.wen,
                    is_load: ctrl.is_load, is_store: ctrl.is_store,
                    mem_width: ctrl.mem_width, is_jump: ctrl.is_jump,
                    illegal: ctrl.illegal};

  // Bubbles leave the latch all zero
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ex_valid      <= 1'b0;
      ctrl_q        <= '0;
      ex_port_a     <= '0;
      ex_port_b     <= '0;
      ex_wdata      <= '0;
      ex_store_data <= '0;
      ex_j_base     <= '0;
      ex_j_offset   <= '0;
      ex_pc         <= '0;
      ex_tag        <= '0;
    end else begin
      ex_valid      <= issue;
      ctrl_q        <= issue ? ctrl_d : '0;
      ex_port_a     <= issue ? port_a : '0;
      ex_port_b     <= issue ? port_b : '0;
      ex_wdata      <= issue ? wdata : '0;
      ex_store_data <= issue ? store_data : '0;
      ex_j_base     <= issue ? j_base : '0;
      ex_j_offset   <= issue ? j_offset : '0;
      ex_pc         <= issue ? pc : '0;
      ex_tag        <= issue ? tag_q : '0;
    end
  end

  assign ex_fu        = ctrl_q.fu;
  assign ex_alu_op    = ctrl_q.alu_op;
  assign ex_rd        = ctrl_q.rd;
  assign ex_wen       = ctrl_q.wen;
  assign ex_is_load   = ctrl_q.is_load;
  assign ex_is_store  = ctrl_q.is_store;
  assign ex_mem_width = ctrl_q.mem_width;
  assign ex_jump      = ctrl_q.is_jump;
  assign ex_illegal   = ctrl_q.illegal;

endmodule

`default_nettype wire

/* decode_stage.sv */
// Decode stage top

`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decode_stage (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   fetch_valid,
  input  decode_pkg::word_t      fetch_instr,
  input  decode_pkg::word_t      fetch_pc,
  output logic                   fetch_ready,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  decode_pkg::word_t      rs1_data,
  input  decode_pkg::word_t      rs2_data,
  input  logic                   flush,
  input  logic                   ex_credit,
  output logic                   ex_valid,
  output logic                   ex_fu,
  output logic [3:0]             ex_alu_op,
  output logic [`REG_ADDR_W-1:0] ex_rd,
  output logic                   ex_wen,
  output decode_pkg::word_t      ex_port_a,
  output decode_pkg::word_t      ex_port_b,
  output decode_pkg::word_t      ex_wdata,
  output decode_pkg::word_t      ex_store_data,
  output logic                   ex_is_load,
  output logic                   ex_is_store,
  output logic [2:0]             ex_mem_width,
  output logic                   ex_jump,
  output decode_pkg::word_t      ex_j_base,
  output decode_pkg::word_t      ex_j_offset,
  output decode_pkg::word_t      ex_pc,
  output logic [`CB_TAG_W-1:0]   ex_tag,
  output logic                   ex_illegal,
  output logic                   icache_flush,
  output logic                   dcache_flush,
  input  logic                   iflush_done,
  input  logic                   dflush_done
);
  import decode_pkg::*;

  word_t port_a, port_b, wdata, j_base, j_offset;
  logic  fence_accept, fence_busy;

  decode_ctrl_if ctrl_bus ();

  // Register file read ports are combinational
  assign rs1_addr = ctrl_bus.rs1;
  assign rs2_addr = ctrl_bus.rs2;

  control_unit u_cu (
    .ctrl  (ctrl_bus.cu),
    .instr (fetch_instr)
  );

  operand_select u_ops (
    .ctrl     (ctrl_bus.ops),
    .pc       (fetch_pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .port_a   (port_a),
    .port_b   (port_b),
    .wdata    (wdata),
    .j_base   (j_base),
    .j_offset (j_offset)
  );

  fence_tracker u_fence (
    .CLK          (CLK),
    .nRST         (nRST),
    .fence_accept (fence_accept),
    .iflush_done  (iflush_done),
    .dflush_done  (dflush_done),
    .icache_flush (icache_flush),
    .dcache_flush (dcache_flush),
    .busy         (fence_busy)
  );

  issue_latch u_issue (
    .CLK           (CLK),
    .nRST          (nRST),
    .ctrl          (ctrl_bus.issue),
    .fetch_valid   (fetch_valid),
    .flush         (flush),
    .fence_busy    (fence_busy),
    .ex_credit     (ex_credit),
    .fetch_ready   (fetch_ready),
    .fence_accept  (fence_accept),
    .pc            (fetch_pc),
    .port_a        (port_a),
    .port_b        (port_b),
    .wdata         (wdata),
    .j_base        (j_base),
    .j_offset      (j_offset),
    .store_data    (rs2_data),
    .ex_valid      (ex_valid),
    .ex_fu         (ex_fu),
    .ex_alu_op     (ex_alu_op),
    .ex_rd         (ex_rd),
    .ex_wen        (ex_wen),
    .ex_port_a     (ex_port_a),
    .ex_port_b     (ex_port_b),
    .ex_wdata      (ex_wdata),
    .ex_store_data (ex_store_data),
    .ex_is_load    (ex_is_load),
    .ex_is_store   (ex_is_store),
    .ex_mem_width  (ex_mem_width),
    .ex_jump       (ex_jump),
    .ex_j_base     (ex_j_base),
    .ex_j_offset   (ex_j_offset),
    .ex_pc         (ex_pc),
    .ex_tag        (ex_tag),
    .ex_illegal    (ex_illegal)
  );

endmodule

`default_nettype wire

/* tb_decode_stage.sv */
// Decode stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module tb_decode_stage;
  import decode_pkg::*;

  // Tests run for about 110 cycles
  localparam int MAX_CYCLES = 2000;

  logic                   CLK, nRST;
  logic                   fetch_valid, fetch_ready;
  word_t                  fetch_instr, fetch_pc;
  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  word_t                  rs1_data, rs2_data;
  logic                   flush, ex_credit;
  logic                   ex_valid, ex_fu, ex_wen, ex_is_load, ex_is_store, ex_jump, ex_illegal;
  logic [3:0]             ex_alu_op;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic [2:0]             ex_mem_width;
  word_t                  ex_port_a, ex_port_b, ex_wdata, ex_store_data;
  word_t                  ex_j_base, ex_j_offset, ex_pc;
  logic [`CB_TAG_W-1:0]   ex_tag, exp_tag;
  logic                   icache_flush, dcache_flush, iflush_done, dflush_done;
  integer                 seed;
  int                     cycles = 0;

  decode_stage u_dut (.*);

  // Register file model where x0 reads as zero
  function automatic word_t reg_model(input logic [`REG_ADDR_W-1:0] a);
    return (a == '0) ? '0 : 32'h8000_1000 + 32'(a) * 32'h0001_0203;
  endfunction

  assign rs1_data = reg_model(rs1_addr);
  assign rs2_data = reg_model(rs2_addr);

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles waiting on the DUT", cycles);
      $display(">>> FAIL");
      $fatal(1, "Timeout");
    end
  end

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Instruction encoders
  function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input logic [4:0] rd,
                                   input logic [6:0] op);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_op(input string name, input alu_op_e got, input alu_op_e exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_tag(input string name, input logic [`CB_TAG_W-1:0] got,
                           input logic [`CB_TAG_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic compare_dest(input logic [4:0] rd, input logic wen);
    check_word("ex_rd", word_t'(ex_rd), word_t'(rd));
    check_bit("ex_wen", ex_wen, wen);
  endtask

  // Present one instruction, wait for acceptance, check the latch a cycle later
  task automatic issue_one(input word_t instr, input word_t pc);
    fetch_valid = 1'b1;
    fetch_instr = instr;
    fetch_pc    = pc;
    #1;
    while (!fetch_ready) begin
      @(negedge CLK);
      #1;
    end
    @(negedge CLK);
    fetch_valid = 1'b0;
    check_bit("ex_valid", ex_valid, 1'b1);
    check_word("ex_pc", ex_pc, pc);
    check_tag("ex_tag", ex_tag, exp_tag);
    exp_tag = exp_tag + 1'b1;
  endtask

  task automatic give_credit();
    ex_credit = 1'b1;
    @(negedge CLK);
    ex_credit = 1'b0;
  endtask

  task automatic refill_credits();
    repeat (`EXEC_CREDITS) give_credit();
  endtask

  // Hold fetch_valid until fetch_ready drops and count the issues
  task automatic drain_credits(input int expected);
    int count;
    count       = 0;
    fetch_valid = 1'b1;
    fetch_instr = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP);
    fetch_pc    = 32'h0000_4000;
    #1;
    while (fetch_ready && count <= expected) begin
      @(negedge CLK);
      check_bit("ex_valid", ex_valid, 1'b1);
      check_tag("ex_tag", ex_tag, exp_tag);
      exp_tag = exp_tag + 1'b1;
      count++;
      #1;
    end
    check_word("issue count", word_t'(count), word_t'(expected));
    @(negedge CLK);
    fetch_valid = 1'b0;
    check_bit("ex_valid", ex_valid, 1'b0);
  endtask

  task automatic alu_ops();
    logic [11:0] imm;
    logic [4:0]  shamt;
    issue_one(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP), 32'h0000_1000);
    check_op("ex_alu_op", alu_op_e'(ex_alu_op), ALU_ADD);
    compare_dest(5'd3, 1'b1);
    check_word("ex_port_a", ex_port_a, reg_model(5'd1));
    check_word("ex_port_b", ex_port_b, reg_model(5'd2));
    give_credit();
    issue_one(r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd7, OP), 32'h0000_1004);
    check_op("ex_alu_op", alu_op_e'(ex_alu_op), ALU_SUB);
    compare_dest(5'd7, 1'b1);
    check_word("ex_port_a", ex_port_a, reg_model(5'd5));
    check_word("ex_port_b", ex_port_b, reg_model(5'd6));
    give_credit();
    imm = 12'($random(seed));
    issue_one(i_type(imm, 5'd4, 3'b000, 5'd9, OP_IMM), 32'h0000_1008);
    check_op("ex_alu_op", alu_op_e'(ex_alu_op), ALU_ADD);
    compare_dest(5'd9, 1'b1);
    check_word("ex_port_a", ex_port_a, reg_model(5'd4));
    check_word("ex_port_b", ex_port_b, sext12(imm));
    give_credit();
    shamt = 5'($random(seed));
    issue_one(i_type({7'h20, shamt}, 5'd8, 3'b101, 5'd10, OP_IMM), 32'h0000_100C);
    check_op("ex_alu_op", alu_op_e'(ex_alu_op), ALU_SRA);
    compare_dest(5'd10, 1'b1);
    check_word("ex_port_a", ex_port_a, reg_model(5'd8));
    check_word("ex_port_b", ex_port_b, {27'b0, shamt});
    give_credit();
  endtask

  task automatic upper_and_jumps();
    logic [19:0] imm20;
    logic [20:0] imm21;
    logic [11:0] imm12;
    word_t       pc;
    pc    = 32'h0001_2340;
    imm20 = 20'($random(seed));
    issue_one(u_type(imm20, 5'd11, LUI), pc);
    compare_dest(5'd11, 1'b1);
    check_word("ex_wdata", ex_wdata, {imm20, 12'h000});
    give_credit();
    issue_one(u_type(imm20, 5'd12, AUIPC), pc);
    compare_dest(5'd12, 1'b1);
    check_word("ex_port_a", ex_port_a, pc);
    check_word("ex_port_b", ex_port_b, {imm20, 12'h000});
    give_credit();
    // J offsets are always even
    imm21 = 21'($random(seed)) & 21'h1F_FFFE;
    issue_one(j_type(imm21, 5'd1, JAL), pc);
    compare_dest(5'd1, 1'b1);
    check_bit("ex_jump", ex_jump, 1'b1);
    check_word("ex_wdata", ex_wdata, pc + 32'd4);
    check_word("ex_j_base", ex_j_base, pc);
    check_word("ex_j_offset", ex_j_offset, {{11{imm21[20]}}, imm21});
    give_credit();
    imm12 = 12'($random(seed));
    issue_one(i_type(imm12, 5'd13, 3'b000, 5'd1, JALR), pc);
    compare_dest(5'd1, 1'b1);
    check_bit("ex_jump", ex_jump, 1'b1);
    check_word("ex_wdata", ex_wdata, pc + 32'd4);
    check_word("ex_j_base", ex_j_base, reg_model(5'd13));
    check_word("ex_j_offset", ex_j_offset, sext12(imm12));
    give_credit();
  endtask

  task automatic loads_and_stores();
    logic [11:0] imm;
    imm = 12'($random(seed));
    issue_one(i_type(imm, 5'd15, 3'b010, 5'd14, LOAD), 32'h0000_2000);
    compare_dest(5'd14, 1'b1);
    check_bit("ex_fu", ex_fu, FU_LOADSTORE);
    check_bit("ex_is_load", ex_is_load, 1'b1);
    check_word("ex_mem_width", word_t'(ex_mem_width), 32'd2);
    check_word("ex_port_a", ex_port_a, reg_model(5'd15));
    check_word("ex_port_b", ex_port_b, sext12(imm));
    give_credit();
    imm = 12'($random(seed));
    issue_one(s_type(imm, 5'd16, 5'd17, 3'b010, STORE), 32'h0000_2004);
    check_bit("ex_wen", ex_wen, 1'b0);
    check_bit("ex_is_store", ex_is_store, 1'b1);
    check_bit("ex_is_load", ex_is_load, 1'b0);
    check_word("ex_port_a", ex_port_a, sext12(imm));
    check_word("ex_port_b", ex_port_b, reg_model(5'd17));
    check_word("ex_store_data", ex_store_data, reg_model(5'd16));
    give_credit();
    issue_one(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd5, 7'h7F), 32'h0000_2008);
    check_bit("ex_illegal", ex_illegal, 1'b1);
    check_bit("ex_wen", ex_wen, 1'b0);
    check_bit("ex_fu", ex_fu, FU_ARITH);
    give_credit();
  endtask

  task automatic credit_flow();
    check_bit("ex_valid", ex_valid, 1'b0);
    drain_credits(`EXEC_CREDITS);
    give_credit();
    drain_credits(1);
    refill_credits();
  endtask

  task automatic tag_wrap_and_flush();
    // Enough issues to wrap the tag counter
    for (int i = 0; i < 9; i++) begin
      issue_one(i_type(12'(i), 5'd1, 3'b000, 5'd2, OP_IMM), 32'h0000_3000 + 32'(4 * i));
      give_credit();
    end
    flush       = 1'b1;
    fetch_valid = 1'b1;
    repeat (3) begin
      #1;
      check_bit("fetch_ready", fetch_ready, 1'b0);
      @(negedge CLK);
      check_bit("ex_valid", ex_valid, 1'b0);
    end
    flush       = 1'b0;
    fetch_valid = 1'b0;
    drain_credits(`EXEC_CREDITS);
    refill_credits();
  endtask

  task automatic fence_i_flush(input logic i_first);
    fetch_valid = 1'b1;
    fetch_instr = i_type(12'h000, 5'd0, 3'b001, 5'd0, MISCMEM);
    fetch_pc    = 32'h0000_5000;
    #1;
    check_bit("fetch_ready", fetch_ready, 1'b1);
    @(negedge CLK);
    check_bit("icache_flush", icache_flush, 1'b1);
    check_bit("dcache_flush", dcache_flush, 1'b1);
    check_bit("ex_valid", ex_valid, 1'b0);
    check_bit("fetch_ready", fetch_ready, 1'b0);
    // Next instruction waits in fetch
    fetch_instr = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP);
    @(negedge CLK);
    check_bit("icache_flush", icache_flush, 1'b0);
    check_bit("dcache_flush", dcache_flush, 1'b0);
    check_bit("fetch_ready", fetch_ready, 1'b0);
    if (i_first) iflush_done = 1'b1;
    else dflush_done = 1'b1;
    @(negedge CLK);
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    check_bit("fetch_ready", fetch_ready, 1'b0);
    check_bit("ex_valid", ex_valid, 1'b0);
    @(negedge CLK);
    check_bit("fetch_ready", fetch_ready, 1'b0);
    if (i_first) dflush_done = 1'b1;
    else iflush_done = 1'b1;
    fetch_valid = 1'b0;
    @(negedge CLK);
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    check_bit("fetch_ready", fetch_ready, 1'b1);
    check_bit("ex_valid", ex_valid, 1'b0);
    drain_credits(`EXEC_CREDITS);
    refill_credits();
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    fetch_pc    = '0;
    flush       = 1'b0;
    ex_credit   = 1'b0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    seed        = 99729;
    exp_tag     = '0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    check_bit("ex_valid", ex_valid, 1'b0);
    check_tag("ex_tag", ex_tag, '0);
    check_word("ex_port_a", ex_port_a, '0);
    check_bit("icache_flush", icache_flush, 1'b0);
    check_bit("dcache_flush", dcache_flush, 1'b0);
    check_bit("fetch_ready", fetch_ready, 1'b1);
    nRST = 1'b1;
    alu_ops();
    upper_and_jumps();
    loads_and_stores();
    credit_flow();
    tag_wrap_and_flush();
    fence_i_flush(1'b1);
    fence_i_flush(1'b0);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
decode_pkg.sv
decode_ctrl_if.sv
control_unit.sv
operand_select.sv
fence_tracker.sv
issue_latch.sv
decode_stage.sv
tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - .
    files:
      - decode_pkg.sv
      - decode_ctrl_if.sv
      - control_unit.sv
      - operand_select.sv
      - fence_tracker.sv
      - issue_latch.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decode_stage.sv
